//--- rtl/cpu_defines.svh
/*
 * Sizing macros for the execute slice.
 * Data width, register count and bus word address width.
 */

`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Width of one data word and of one instruction word
`define DATA_W 16

// Number of general purpose registers, none hard-wired to zero
`define REG_CNT 16

// Wishbone word address width, covers the control regs and the register window
`define ADR_W 5

`endif

//--- rtl/isa_pkg.sv
/*
 * Instruction set package.
 * Instruction word union, opcode values and flag bit positions.
 */

package isa_pkg;

  ////////////////////////////////////////////////////////////
  // Instruction word layouts
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [3:0] opcode;  // Operation
    logic [3:0] rd;      // Destination register
    logic [3:0] rs;      // First source register
    logic [3:0] rt;      // Second source, or shift amount for shifts
  } r_form_t;

  typedef struct packed {
    logic [3:0] opcode;  // Operation
    logic [3:0] rd;      // Destination, also the byte-load base
    logic [7:0] imm;     // Byte immediate for LLB and LHB
  } i_form_t;

  // One 16-bit word seen either way
  typedef union packed {
    r_form_t r_form;
    i_form_t i_form;
  } instr_u;

  // Opcode values, anything not listed is illegal in this slice
  localparam logic [3:0] OP_ADD    = 4'h0;
  localparam logic [3:0] OP_SUB    = 4'h1;
  localparam logic [3:0] OP_XOR    = 4'h2;
  localparam logic [3:0] OP_RED    = 4'h3;
  localparam logic [3:0] OP_SLL    = 4'h4;
  localparam logic [3:0] OP_SRA    = 4'h5;
  localparam logic [3:0] OP_ROR    = 4'h6;
  localparam logic [3:0] OP_PADDSB = 4'h7;
  localparam logic [3:0] OP_LLB    = 4'hA;
  localparam logic [3:0] OP_LHB    = 4'hB;

  // Flag word layout, N V Z from msb down
  localparam int FLAG_W = 3;
  localparam int FLAG_Z = 0;
  localparam int FLAG_V = 1;
  localparam int FLAG_N = 2;

endpackage

//--- rtl/wb_pkg.sv
/*
 * Wishbone slave register map.
 * Word addresses of the control registers and status bit positions.
 */

`include "cpu_defines.svh"

package wb_pkg;

  // Control registers
  localparam logic [`ADR_W-1:0] ADR_INSTR  = `ADR_W'('h00);  // Write runs the instruction
  localparam logic [`ADR_W-1:0] ADR_FLAGS  = `ADR_W'('h01);  // N V Z, read only
  localparam logic [`ADR_W-1:0] ADR_STATUS = `ADR_W'('h02);  // Sticky status bits

  // Register window, r0 at the base up to r15 at 0x1F
  localparam logic [`ADR_W-1:0] ADR_REG_BASE = `ADR_W'('h10);

  // Status register bits
  // Write 1 to clear
  localparam int STAT_ILLEGAL = 0;

endpackage

//--- rtl/alu_if.sv
/*
 * Combinational link between the execute core and the ALU.
 * Operands and opcode go out, result and flag-set signals come back.
 */

`timescale 1ns/1ns

`include "cpu_defines.svh"

interface alu_if;

  logic [`DATA_W-1:0] in1;     // First operand, rs or rd
  logic [`DATA_W-1:0] in2;     // Second operand, rt, shift amount or imm
  logic [3:0]         opcode;  // Raw opcode field
  logic [`DATA_W-1:0] result;  // ALU output
  logic               z_set;   // Result is zero
  logic               v_set;   // Signed overflow on ADD or SUB
  logic               n_set;   // Result sign bit

  // Core side
  modport ctrl (output in1, in2, opcode, input result, z_set, v_set, n_set);

  // ALU side
  modport unit (input in1, in2, opcode, output result, z_set, v_set, n_set);

endinterface

//--- rtl/alu.sv
/*
 * 16-bit combinational ALU.
 * Saturating ADD and SUB, XOR, byte reduction, packed nibble add,
 * shifts by a 4-bit amount and the two byte loads.
 */

`timescale 1ns/1ns

`include "cpu_defines.svh"

module alu (
  alu_if.unit bus  // Operands in, result and flag-set signals out
);

  ////////////////////////////////////////////////////////////
  // Saturating add and subtract
  ////////////////////////////////////////////////////////////
  logic                 is_sub;    // SUB selects two's complement of in2
  logic                 is_addsub; // Only these two report overflow
  logic [`DATA_W-1:0]   b_eff;     // in2 or its inverse
  logic [`DATA_W-1:0]   add_raw;   // Wrapping sum
  logic                 add_ov;    // Signed overflow of the wrapping sum
  logic [`DATA_W-1:0]   add_sat;   // Clamped sum

  assign is_sub    = (bus.opcode == isa_pkg::OP_SUB);
  assign is_addsub = (bus.opcode == isa_pkg::OP_ADD) | is_sub;

  assign b_eff   = is_sub ? ~bus.in2 : bus.in2;
  assign add_raw = bus.in1 + b_eff + `DATA_W'(is_sub);  // Carry-in completes the negate

  // Same sign operands, result sign flipped
  assign add_ov = (bus.in1[`DATA_W-1] == b_eff[`DATA_W-1]) &
                  (add_raw[`DATA_W-1] != bus.in1[`DATA_W-1]);

  // Clamp toward the operand sign
  assign add_sat = !add_ov             ? add_raw :
                   bus.in1[`DATA_W-1]  ? {1'b1, {(`DATA_W-1){1'b0}}} :  // 8000
                                         {1'b0, {(`DATA_W-1){1'b1}}};   // 7FFF

  ////////////////////////////////////////////////////////////
  // Byte reduction
  ////////////////////////////////////////////////////////////
  // Four signed bytes summed at 10 bits, never overflows
  logic [9:0] red_sum;

  assign red_sum = {{2{bus.in1[15]}}, bus.in1[15:8]} +
                   {{2{bus.in1[7]}},  bus.in1[7:0]}  +
                   {{2{bus.in2[15]}}, bus.in2[15:8]} +
                   {{2{bus.in2[7]}},  bus.in2[7:0]};

  ////////////////////////////////////////////////////////////
  // Packed nibble add with per-lane saturation
  ////////////////////////////////////////////////////////////
  logic [`DATA_W-1:0] pad_res;

  for (genvar i = 0; i < `DATA_W/4; i++) begin : g_nib
    logic [4:0] nsum;  // Sign-extended lane sum

    assign nsum = {bus.in1[4*i+3], bus.in1[4*i+3 -: 4]} +
                  {bus.in2[4*i+3], bus.in2[4*i+3 -: 4]};

    // Top two bits disagree on lane overflow
    assign pad_res[4*i +: 4] = (nsum[4] == nsum[3]) ? nsum[3:0] :
                               nsum[4]              ? 4'h8 : 4'h7;
  end

  ////////////////////////////////////////////////////////////
  // Shifts
  ////////////////////////////////////////////////////////////
  logic [3:0]           shamt;    // Amount from the low nibble of in2
  logic [`DATA_W-1:0]   sll_res;
  logic [`DATA_W-1:0]   sra_res;
  logic [2*`DATA_W-1:0] rot_dbl;  // Doubled word, low half is the rotate

  assign shamt   = bus.in2[3:0];
  assign sll_res = bus.in1 << shamt;
  assign sra_res = $signed(bus.in1) >>> shamt;
  assign rot_dbl = {bus.in1, bus.in1} >> shamt;

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (bus.opcode)
      isa_pkg::OP_ADD,
      isa_pkg::OP_SUB:    bus.result = add_sat;
      isa_pkg::OP_XOR:    bus.result = bus.in1 ^ bus.in2;
      isa_pkg::OP_RED:    bus.result = {{(`DATA_W-10){red_sum[9]}}, red_sum};
      isa_pkg::OP_SLL:    bus.result = sll_res;
      isa_pkg::OP_SRA:    bus.result = sra_res;
      isa_pkg::OP_ROR:    bus.result = rot_dbl[`DATA_W-1:0];
      isa_pkg::OP_PADDSB: bus.result = pad_res;
      isa_pkg::OP_LLB:    bus.result = {bus.in1[15:8], bus.in2[7:0]};  // Keep high byte
      isa_pkg::OP_LHB:    bus.result = {bus.in2[7:0], bus.in1[7:0]};   // Keep low byte
      default:            bus.result = '0;  // Illegal, core writes nothing
    endcase
  end

  // Flag candidates, the core decides which ones land
  assign bus.z_set = (bus.result == '0);
  assign bus.v_set = add_ov & is_addsub;
  assign bus.n_set = bus.result[`DATA_W-1];

endmodule

//--- rtl/reg_file.sv
/*
 * Sixteen-word register file.
 * Two core read ports and a bus read port, all combinational,
 * plus separate core and bus write ports.
 */

`timescale 1ns/1ns

`include "cpu_defines.svh"

module reg_file (
  input  logic               clk,
  input  logic [3:0]         rs_addr,    // Core read port A
  input  logic [3:0]         rt_addr,    // Core read port B
  output logic [`DATA_W-1:0] rs_data,
  output logic [`DATA_W-1:0] rt_data,
  input  logic               core_we,    // Write back from execute
  input  logic [3:0]         core_addr,
  input  logic [`DATA_W-1:0] core_data,
  input  logic               bus_we,     // Host write through the window
  input  logic [3:0]         bus_addr,
  input  logic [`DATA_W-1:0] bus_wdata,
  output logic [`DATA_W-1:0] bus_rdata   // Host read through the window
);

  logic [`DATA_W-1:0] regs [`REG_CNT];  // Storage, power-up contents undefined

  // Reads see the array directly, no bypass needed since
  // a write lands on the same edge as the bus ack
  assign rs_data   = regs[rs_addr];
  assign rt_data   = regs[rt_addr];
  assign bus_rdata = regs[bus_addr];

  ////////////////////////////////////////////////////////////
  // Write ports
  ////////////////////////////////////////////////////////////
  // One bus access at a time keeps the two ports apart
  always_ff @(posedge clk) begin
    if (core_we) begin
      regs[core_addr] <= core_data;
    end
    if (bus_we) begin
      regs[bus_addr] <= bus_wdata;
    end
  end

endmodule

//--- rtl/exec_core.sv
/*
 * Single-cycle execute stage.
 * Decodes one instruction word, feeds the ALU, writes rd back and
 * updates the flags by opcode class; flags illegal opcodes.
 */

`timescale 1ns/1ns

`include "cpu_defines.svh"

module exec_core (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          exec,           // Run instr this cycle
  input  isa_pkg::instr_u               instr,
  input  logic                          clear_illegal,  // Host write of 1 to STATUS
  output logic [3:0]                    rs_addr,
  output logic [3:0]                    rt_addr,
  input  logic [`DATA_W-1:0]            rs_data,
  input  logic [`DATA_W-1:0]            rt_data,
  output logic                          core_we,
  output logic [3:0]                    core_addr,
  output logic [`DATA_W-1:0]            core_data,
  alu_if.ctrl                           alu,
  output logic [isa_pkg::FLAG_W-1:0]    flags,          // N V Z
  output logic                          illegal         // Sticky
);

  logic [3:0] opcode;
  logic       is_lb;    // LLB or LHB, first operand is rd
  logic       is_shift; // Second operand is the rt field itself
  logic       legal;
  logic       upd_zvn;  // Arithmetic class
  logic       upd_z;    // Logic and shift class

  assign opcode   = instr.r_form.opcode;
  assign is_lb    = (opcode == isa_pkg::OP_LLB) | (opcode == isa_pkg::OP_LHB);
  assign is_shift = (opcode == isa_pkg::OP_SLL) | (opcode == isa_pkg::OP_SRA) |
                    (opcode == isa_pkg::OP_ROR);

  ////////////////////////////////////////////////////////////
  // Operand fetch
  ////////////////////////////////////////////////////////////
  assign rs_addr = is_lb ? instr.i_form.rd : instr.r_form.rs;
  assign rt_addr = instr.r_form.rt;

  assign alu.opcode = opcode;
  assign alu.in1    = rs_data;
  assign alu.in2    = is_lb    ? `DATA_W'(instr.i_form.imm) :   // Zero-extended byte
                      is_shift ? `DATA_W'(instr.r_form.rt)  :   // Shift amount
                                 rt_data;

  // Opcode class decode
  always_comb begin
    legal   = 1'b1;
    upd_zvn = 1'b0;
    upd_z   = 1'b0;
    case (opcode)
      isa_pkg::OP_ADD, isa_pkg::OP_SUB: upd_zvn = 1'b1;
      isa_pkg::OP_XOR, isa_pkg::OP_SLL,
      isa_pkg::OP_SRA, isa_pkg::OP_ROR: upd_z = 1'b1;
      isa_pkg::OP_RED, isa_pkg::OP_PADDSB,
      isa_pkg::OP_LLB, isa_pkg::OP_LHB: begin
        // Flags untouched
      end
      default: legal = 1'b0;  // LW, SW and 0xC to 0xF
    endcase
  end

  // Write back
  assign core_we   = exec & legal;
  assign core_addr = instr.i_form.rd;
  assign core_data = alu.result;

  ////////////////////////////////////////////////////////////
  // Flags and illegal bit
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags   <= '0;
      illegal <= 1'b0;
    end else begin
      if (core_we && upd_zvn) begin
        flags[isa_pkg::FLAG_Z] <= alu.z_set;
        flags[isa_pkg::FLAG_V] <= alu.v_set;
        flags[isa_pkg::FLAG_N] <= alu.n_set;
      end else if (core_we && upd_z) begin
        flags[isa_pkg::FLAG_Z] <= alu.z_set;  // V and N hold
      end
      if (exec && !legal) illegal <= 1'b1;
      else if (clear_illegal) illegal <= 1'b0;
    end
  end

endmodule

//--- rtl/wb_exec_top.sv
/*
 * Execute slice top with a Wishbone classic slave port.
 * Decodes control registers and the register window, acks each access.
 */

`timescale 1ns/1ns

`include "cpu_defines.svh"

module wb_exec_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cyc,
  input  logic               stb,
  input  logic               we,
  input  logic [`ADR_W-1:0]  adr,
  input  logic [`DATA_W-1:0] dat_w,
  output logic [`DATA_W-1:0] dat_r,
  output logic               ack
);

  logic                        new_req;       // First cycle of an access
  logic                        wr_stb;        // Single-cycle write strobe
  logic                        in_win;        // Address in 0x10..0x1F
  logic                        exec;
  logic                        bus_we;
  logic                        clear_illegal;
  logic [`DATA_W-1:0]          bus_rdata;
  logic [isa_pkg::FLAG_W-1:0]  flags;
  logic                        illegal;
  logic [3:0]                  rs_addr, rt_addr, core_addr;
  logic [`DATA_W-1:0]          rs_data, rt_data, core_data;
  logic                        core_we;
  isa_pkg::instr_u             instr_word;

  ////////////////////////////////////////////////////////////
  // Bus handshake
  ////////////////////////////////////////////////////////////
  assign new_req = cyc & stb & ~ack;
  assign wr_stb  = new_req & we;

  // One-cycle ack, held stb restarts after a low cycle
  always_ff @(posedge clk) begin
    if (!rst_n) ack <= 1'b0;
    else        ack <= new_req;
  end

  // Address decode
  assign in_win        = (adr[`ADR_W-1:4] == wb_pkg::ADR_REG_BASE[`ADR_W-1:4]);
  assign exec          = wr_stb & (adr == wb_pkg::ADR_INSTR);
  assign bus_we        = wr_stb & in_win;
  assign clear_illegal = wr_stb & (adr == wb_pkg::ADR_STATUS) & dat_w[wb_pkg::STAT_ILLEGAL];
  assign instr_word    = dat_w;

  // Read mux, unmapped reads give zero
  always_comb begin
    dat_r = '0;
    if (in_win) dat_r = bus_rdata;
    else if (adr == wb_pkg::ADR_FLAGS) dat_r = `DATA_W'(flags);
    else if (adr == wb_pkg::ADR_STATUS) dat_r[wb_pkg::STAT_ILLEGAL] = illegal;
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////
  alu_if alu_bus ();

  alu alu_i (.bus(alu_bus));

  reg_file rf_i (
    .clk, .rs_addr, .rt_addr, .rs_data, .rt_data,
    .core_we, .core_addr, .core_data,
    .bus_we, .bus_addr(adr[3:0]), .bus_wdata(dat_w), .bus_rdata
  );

  exec_core core_i (
    .clk, .rst_n, .exec, .instr(instr_word), .clear_illegal,
    .rs_addr, .rt_addr, .rs_data, .rt_data,
    .core_we, .core_addr, .core_data,
    .alu(alu_bus), .flags, .illegal
  );

endmodule

//--- dv/exec_properties.sv
/*
 * Bus handshake and flag properties for the execute slice top.
 */

`timescale 1ns/1ns

`include "cpu_defines.svh"

module exec_properties (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       cyc,
  input logic                       stb,
  input logic                       we,
  input logic [`ADR_W-1:0]          adr,
  input logic                       ack,
  input logic [isa_pkg::FLAG_W-1:0] flags
);

  int fail_cnt = 0;  // Number of failed assertions

  ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
    else begin
      $error("ack held high for more than one cycle");
      fail_cnt++;
    end

  ack_after_req: assert property (@(posedge clk) disable iff (!rst_n) ack |-> $past(cyc && stb))
    else begin
      $error("ack without a preceding request");
      fail_cnt++;
    end

  ack_low_in_reset: assert property (@(posedge clk) !rst_n |=> !ack)
    else begin
      $error("ack high after reset");
      fail_cnt++;
    end

  // Flags move only on the ack of an instruction write, decoded in the request cycle
  flags_stable: assert property (@(posedge clk) disable iff (!rst_n)
      $changed(flags) |-> ack && $past(we && (adr == wb_pkg::ADR_INSTR)))
    else begin
      $error("flags changed without an instruction write");
      fail_cnt++;
    end

endmodule

bind wb_exec_top exec_properties props_i (.clk, .rst_n, .cyc, .stb, .we, .adr, .ack, .flags);

//--- dv/exec_tb.sv
/*
 * Directed testbench for the Wishbone execute slice.
 * Bus tasks, a shadow register file, a reference model and one task per test.
 */

`timescale 1ns/1ns

`include "cpu_defines.svh"

module exec_tb;

  localparam int CYCLE_LIMIT = 20000;  // Well above the ~1300 cycles of a full run
  localparam int ACK_WAIT    = 10;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               cyc, stb, we;
  logic [`ADR_W-1:0]  adr;
  logic [`DATA_W-1:0] dat_w, dat_r;
  logic               ack;

  logic [`DATA_W-1:0] exp_regs [`REG_CNT];  // Shadow of the register file
  logic [2:0]         exp_flags;            // Shadow flags, N V Z
  integer             seed = 63;
  int                 errors = 0;
  int                 checks = 0;
  int                 cycles = 0;

  always #4 clk = ~clk;  // 8 ns period

  wb_exec_top dut_i (.clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack);

  //////////////////////////////////////////////////////////////
  // Bus and check helpers
  //////////////////////////////////////////////////////////////
  function automatic logic [15:0] rnd16();
    logic [31:0] r;
    r = $random(seed);
    rnd16 = r[15:0];
  endfunction

  task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // One classic cycle, request on a falling edge, ack sampled on falling edges
  task automatic bus_access(input logic wr, input logic [`ADR_W-1:0] a,
                            input logic [15:0] wd, output logic [15:0] rd);
    int n;
    @(negedge clk);
    cyc = 1'b1;
    stb = 1'b1;
    we = wr;
    adr = a;
    dat_w = wd;
    @(negedge clk);
    n = 1;
    while (!ack && n < ACK_WAIT) begin
      @(negedge clk);
      n++;
    end
    rd = dat_r;  // Read mux output is stable here
    if (!ack) begin
      $display("no acknowledge from slave at address 0x%h", a);
      errors++;
    end else begin
      check("ack latency", 16'(n), 16'd1);  // Ack in the cycle after the request
    end
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;  // No pipelining
  endtask

  task automatic wb_write(input logic [`ADR_W-1:0] a, input logic [15:0] d);
    logic [15:0] unused;
    bus_access(1'b1, a, d, unused);
  endtask

  task automatic wb_read(input logic [`ADR_W-1:0] a, output logic [15:0] d);
    bus_access(1'b0, a, 16'h0000, d);
  endtask

  task automatic reg_write(input logic [3:0] idx, input logic [15:0] v);
    wb_write(wb_pkg::ADR_REG_BASE + `ADR_W'(idx), v);
    exp_regs[idx] = v;
  endtask

  task automatic verify_regs();
    logic [15:0] got;
    for (int i = 0; i < `REG_CNT; i++) begin
      wb_read(wb_pkg::ADR_REG_BASE + `ADR_W'(i), got);
      check($sformatf("r%0d", i), got, exp_regs[i]);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Reference model, returns {flags, result}
  //////////////////////////////////////////////////////////////
  function automatic logic [18:0] ref_model(input logic [3:0] op, input logic [15:0] a,
                                            input logic [15:0] b, input logic [2:0] fl);
    integer      sa, sb, s, la, lb;
    logic [15:0] r;
    logic [2:0]  nf;
    r  = 16'h0000;
    nf = fl;
    sa = $signed(a);
    sb = $signed(b);
    case (op)
      isa_pkg::OP_ADD, isa_pkg::OP_SUB: begin
        s = (op == isa_pkg::OP_ADD) ? sa + sb : sa - sb;
        r = (s > 32767) ? 16'h7fff : (s < -32768) ? 16'h8000 : s[15:0];
        nf[isa_pkg::FLAG_V] = (s > 32767) || (s < -32768);
        nf[isa_pkg::FLAG_N] = r[15];
      end
      isa_pkg::OP_XOR: r = a ^ b;
      isa_pkg::OP_RED: begin
        s = $signed(a[15:8]) + $signed(a[7:0]) + $signed(b[15:8]) + $signed(b[7:0]);
        r = s[15:0];  // Sign extension comes from the integer
      end
      isa_pkg::OP_PADDSB: begin
        for (int i = 0; i < 4; i++) begin
          la = $signed(a[4*i +: 4]);
          lb = $signed(b[4*i +: 4]);
          s  = la + lb;
          if (s > 7) s = 7;
          if (s < -8) s = -8;
          r[4*i +: 4] = s[3:0];
        end
      end
      isa_pkg::OP_SLL: begin
        r = a;
        for (int i = 0; i < b[3:0]; i++) r = {r[14:0], 1'b0};  // Zero enters at bit 0
      end
      isa_pkg::OP_SRA: begin
        r = a;
        for (int i = 0; i < b[3:0]; i++) r = {r[15], r[15:1]};  // Sign bit refills
      end
      isa_pkg::OP_ROR: begin
        r = a;
        for (int i = 0; i < b[3:0]; i++) r = {r[0], r[15:1]};  // One bit per step
      end
      isa_pkg::OP_LLB: r = {a[15:8], b[7:0]};
      isa_pkg::OP_LHB: r = {b[7:0], a[7:0]};
      default: r = 16'h0000;
    endcase
    // Z for the arithmetic, logic and shift classes
    if (op inside {isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_XOR, isa_pkg::OP_SLL,
                   isa_pkg::OP_SRA, isa_pkg::OP_ROR})
      nf[isa_pkg::FLAG_Z] = (r == 16'h0000);
    ref_model = {nf, r};
  endfunction

  // Loads operands, runs one instruction, checks rd and the flags
  task automatic run_instr(input logic [3:0] op, input logic [3:0] rd, input logic [3:0] rs,
                           input logic [3:0] rt, input logic [15:0] a, input logic [15:0] b);
    logic [15:0] in1, in2, got;
    logic [18:0] exp;
    if (op == isa_pkg::OP_LLB || op == isa_pkg::OP_LHB) begin
      reg_write(rd, a);  // rd is also the base
      in1 = exp_regs[rd];
      in2 = {8'h00, b[7:0]};
      wb_write(wb_pkg::ADR_INSTR, {op, rd, b[7:0]});
    end else if (op inside {isa_pkg::OP_SLL, isa_pkg::OP_SRA, isa_pkg::OP_ROR}) begin
      reg_write(rs, a);
      in1 = exp_regs[rs];
      in2 = {12'h000, b[3:0]};
      wb_write(wb_pkg::ADR_INSTR, {op, rd, rs, b[3:0]});
    end else begin
      reg_write(rs, a);
      reg_write(rt, b);  // Overwrites a when rs equals rt
      in1 = exp_regs[rs];
      in2 = exp_regs[rt];
      wb_write(wb_pkg::ADR_INSTR, {op, rd, rs, rt});
    end
    exp           = ref_model(op, in1, in2, exp_flags);
    exp_regs[rd]  = exp[15:0];
    exp_flags     = exp[18:16];
    wb_read(wb_pkg::ADR_REG_BASE + `ADR_W'(rd), got);
    check($sformatf("r%0d op %h", rd, op), got, exp[15:0]);
    wb_read(wb_pkg::ADR_FLAGS, got);
    check("flags", got, {13'h0000, exp_flags});
  endtask

  task automatic report_test(input string name, input int err0);
    $display("test %s finished, %0d errors", name, errors - err0);
  endtask

  //////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////
  task automatic reg_window();
    int          err0;
    logic [15:0] got;
    err0 = errors;
    wb_read(wb_pkg::ADR_FLAGS, got);
    check("flags", got, 16'h0000);
    wb_read(wb_pkg::ADR_STATUS, got);
    check("status", got, 16'h0000);
    for (int i = 0; i < `REG_CNT; i++) reg_write(i[3:0], rnd16());
    verify_regs();
    report_test("reg_window", err0);
  endtask

  task automatic add_sub_sat();
    int          err0;
    logic [15:0] r, x;
    err0 = errors;
    run_instr(isa_pkg::OP_ADD, 4'd5, 4'd1, 4'd2, 16'h7fff, 16'h0001);  // Positive clamp
    run_instr(isa_pkg::OP_SUB, 4'd6, 4'd1, 4'd2, 16'h8000, 16'h0001);  // Negative clamp
    run_instr(isa_pkg::OP_ADD, 4'd7, 4'd3, 4'd4, 16'h8000, 16'hffff);
    x = rnd16();
    run_instr(isa_pkg::OP_SUB, 4'd8, 4'd4, 4'd4, x, x);  // x - x gives Z
    for (int i = 0; i < 24; i++) begin
      r = rnd16();
      run_instr(i[0] ? isa_pkg::OP_SUB : isa_pkg::OP_ADD, r[3:0], r[7:4], r[11:8],
                rnd16(), rnd16());
    end
    report_test("add_sub_sat", err0);
  endtask

  task automatic logic_ops();
    int          err0;
    logic [15:0] r, x;
    logic [3:0]  ops [3];
    err0 = errors;
    ops[0] = isa_pkg::OP_RED;
    ops[1] = isa_pkg::OP_PADDSB;
    ops[2] = isa_pkg::OP_XOR;
    x = rnd16();
    run_instr(isa_pkg::OP_XOR, 4'd10, 4'd3, 4'd3, x, x);  // Zero result sets Z
    for (int i = 0; i < 24; i++) begin
      r = rnd16();
      run_instr(ops[i % 3], r[3:0], r[7:4], r[11:8], rnd16(), rnd16());
    end
    report_test("logic_ops", err0);
  endtask

  task automatic shift_ops();
    int          err0;
    logic [15:0] r;
    err0 = errors;
    run_instr(isa_pkg::OP_SUB, 4'd0, 4'd1, 4'd2, 16'h8000, 16'h0001);  // Set V and N first
    for (int sh = 0; sh < 16; sh++) begin
      r = rnd16();
      run_instr(isa_pkg::OP_SLL, r[3:0], r[7:4], 4'd0, rnd16(), 16'(sh));
      run_instr(isa_pkg::OP_SRA, r[7:4], r[11:8], 4'd0, rnd16(), 16'(sh));
      run_instr(isa_pkg::OP_ROR, r[11:8], r[15:12], 4'd0, rnd16(), 16'(sh));
    end
    run_instr(isa_pkg::OP_SLL, 4'd3, 4'd4, 4'd0, 16'h8000, 16'd1);  // Shifted out to zero
    report_test("shift_ops", err0);
  endtask

  task automatic byte_loads();
    int          err0;
    logic [15:0] r;
    err0 = errors;
    for (int i = 0; i < 16; i++) begin
      r = rnd16();
      run_instr(i[0] ? isa_pkg::OP_LHB : isa_pkg::OP_LLB, r[3:0], 4'd0, 4'd0,
                rnd16(), rnd16());
    end
    report_test("byte_loads", err0);
  endtask

  task automatic illegal_opcodes();
    int          err0;
    logic [15:0] r, got;
    logic [3:0]  ops [6];
    err0 = errors;
    ops[0] = 4'h8;  // LW
    ops[1] = 4'h9;  // SW
    ops[2] = 4'hC;
    ops[3] = 4'hD;
    ops[4] = 4'hE;
    ops[5] = 4'hF;
    for (int i = 0; i < 6; i++) begin
      r = rnd16();
      wb_write(wb_pkg::ADR_INSTR, {ops[i], r[11:0]});
      wb_read(wb_pkg::ADR_STATUS, got);
      check("status", got, 16'h0001);
      wb_read(wb_pkg::ADR_FLAGS, got);
      check("flags", got, {13'h0000, exp_flags});
      wb_write(wb_pkg::ADR_STATUS, 16'h0001);  // Each opcode must set it again
      wb_read(wb_pkg::ADR_STATUS, got);
      check("status", got, 16'h0000);
    end
    verify_regs();  // Nothing written by any of them
    run_instr(isa_pkg::OP_ADD, 4'd9, 4'd1, 4'd2, rnd16(), rnd16());
    report_test("illegal_opcodes", err0);
  endtask

  //////////////////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////////////////
  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, tests did not complete", cycles);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    exp_flags = 3'b000;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    reg_window();
    add_sub_sat();
    logic_ops();
    shift_ops();
    byte_loads();
    illegal_opcodes();
    errors += dut_i.props_i.fail_cnt;  // Bound assertion failures count too
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) $display("Test OK");
    else $display("Test FAILED");
    $finish;
  end

endmodule

//--- compile.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/wb_pkg.sv
rtl/alu_if.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/exec_core.sv
rtl/wb_exec_top.sv
dv/exec_properties.sv
dv/exec_tb.sv

//--- Bender.yml
package:
  name: wb_exec

export_include_dirs:
  - rtl

sources:
  - rtl/isa_pkg.sv
  - rtl/wb_pkg.sv
  - rtl/alu_if.sv
  - rtl/alu.sv
  - rtl/reg_file.sv
  - rtl/exec_core.sv
  - rtl/wb_exec_top.sv
  - target: test
    files:
      - dv/exec_properties.sv
      - dv/exec_tb.sv
